/* sim/alu_patterns.txt */
// Columns: switch A, switch B, operation code, expected result (hex bytes)
// A line with code ff ends the table
12 34 20 46
ff 01 20 00
80 80 20 00
7f 01 20 80
50 20 22 30
00 01 22 ff
10 20 22 f0
f0 3c 24 30
ff 00 24 00
f0 0f 25 ff
a0 05 25 a5
ff 0f 26 f0
aa aa 26 00
00 00 27 ff
f0 0f 27 00
12 34 27 c9
80 03 02 10
ff 07 02 01
ff 08 02 00
81 ff 02 00
80 03 03 f0
90 02 03 e4
7f 03 03 0f
80 08 03 ff
7f 09 03 00
c0 ff 03 ff
12 34 00 00
12 34 21 00
12 34 3f 00
00 00 ff 00

/* sources.f */
hw/alu_pkg.sv
hw/button_capture.sv
hw/alu_input_ctrl.sv
hw/alu.sv
hw/alu_board_top.sv
sim/alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module alu_tb -f sources.f -o alu_tb_sim

./obj_dir/alu_tb_sim | tee "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
echo "Simulation passed"

/* sim/alu_tb.sv */
module alu_tb;

    localparam int CLK_HALF = 20;             // 40 unit period
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM = 200;
    localparam int MAX_PATTERNS = 64;
    localparam int CYCLES_PER_TEST = 30;      // Budget for the watchdog
    localparam logic [31:0] LFSR_SEED = 32'hdfe7d001;

    logic                     clock;
    logic                     rst;
    logic [alu_pkg::SW_W-1:0] sw;
    logic                     button_a;
    logic                     button_b;
    logic                     button_op;
    alu_pkg::operand_t        alu_result;

    // Four bytes per test for A, B, code and expected result
    logic [7:0]  pattern_mem [0:4*MAX_PATTERNS-1];
    logic [31:0] lfsr_state;
    int          error_count;
    int          num_patterns;
    int          cycle_count;
    int          cycle_limit;

    alu_board_top dut0 (
        .i_clock      (clock),
        .i_rst        (rst),
        .i_sw         (sw),
        .i_button_a   (button_a),
        .i_button_b   (button_b),
        .i_button_op  (button_op),
        .o_alu_result (alu_result)
    );

    always #(CLK_HALF) clock = ~clock;

    // Watchdog on elapsed cycles
    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("Run did not finish within %0d cycles, stopped by watchdog", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic alu_pkg::opcode_t code_from_index(input logic [2:0] index);
        case (index)
            3'd0:    return alu_pkg::OP_ADD;
            3'd1:    return alu_pkg::OP_SUB;
            3'd2:    return alu_pkg::OP_AND;
            3'd3:    return alu_pkg::OP_OR;
            3'd4:    return alu_pkg::OP_XOR;
            3'd5:    return alu_pkg::OP_NOR;
            3'd6:    return alu_pkg::OP_SRL;
            default: return alu_pkg::OP_SRA;
        endcase
    endfunction

    // Reference model from the operation rules
    function automatic alu_pkg::operand_t expected_result(input alu_pkg::operand_t a,
        input alu_pkg::operand_t b, input alu_pkg::opcode_t op);
        alu_pkg::operand_t r;
        int                modulus;
        int                i;
        int                src;
        logic              fill;
        modulus = 1 << alu_pkg::DATA_W;
        r = '0;
        fill = (op == alu_pkg::OP_SRA) ? a[alu_pkg::DATA_W-1] : 1'b0;
        case (op)
            alu_pkg::OP_ADD: r = alu_pkg::operand_t'((int'(a) + int'(b)) % modulus);
            alu_pkg::OP_SUB: r = alu_pkg::operand_t'((int'(a) - int'(b) + modulus) % modulus);
            alu_pkg::OP_AND: r = a & b;
            alu_pkg::OP_OR:  r = a | b;
            alu_pkg::OP_XOR: r = a ^ b;
            alu_pkg::OP_NOR: r = ~a & ~b;              // De Morgan form
            alu_pkg::OP_SRL, alu_pkg::OP_SRA:
            begin
                for (i = 0; i < alu_pkg::DATA_W; i++)
                begin
                    src = i + int'(b);                 // Source bit before the shift
                    r[i] = (src < alu_pkg::DATA_W) ? a[src] : fill;
                end
            end
            default: r = '0;                           // Not an operation
        endcase
        return r;
    endfunction

    task automatic set_button(input int which, input logic level);
        case (which)
            0:       button_a = level;
            1:       button_b = level;
            default: button_op = level;
        endcase
    endtask

    // Starts and ends on a falling edge
    task automatic press_button(input int which, input logic [alu_pkg::SW_W-1:0] value);
        sw = value;
        set_button(which, 1'b1);
        repeat (3) @(negedge clock);                  // High for three rising edges
        set_button(which, 1'b0);
        repeat (2) @(negedge clock);                  // Let the synchronizer see low
    endtask

    task automatic check_result(input alu_pkg::operand_t expected, input string what);
        if (alu_result !== expected)
        begin
            error_count++;
            $display("ERR %0t: %s gave %h, expected %h", $time, what, alu_result, expected);
        end
    endtask

    // Upper switches carry junk to prove the slices
    task automatic run_test(input alu_pkg::operand_t a, input alu_pkg::operand_t b,
        input alu_pkg::opcode_t op, input alu_pkg::operand_t expected, input string what);
        press_button(0, {~a, a});
        press_button(1, {~b, b});
        press_button(2, {8'ha5, 2'b11, op});
        repeat (6) @(negedge clock);
        check_result(expected, what);
    endtask

    initial
    begin
        logic [31:0]       bits;
        alu_pkg::operand_t a;
        alu_pkg::operand_t b;
        alu_pkg::opcode_t  op;
        logic              found_end;
        int                i;

        clock = 1'b0;
        rst = 1'b1;
        sw = 16'h0027;                                 // NOR code makes any stray capture nonzero
        button_a = 1'b0;
        button_b = 1'b0;
        button_op = 1'b0;
        lfsr_state = LFSR_SEED;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = 0;

        // Code column ff marks the end of the table
        $readmemh("sim/alu_patterns.txt", pattern_mem);
        num_patterns = 0;
        found_end = 1'b0;
        for (i = 0; i < MAX_PATTERNS; i++)
        begin
            if (!found_end)
            begin
                if (pattern_mem[4*i+2] == 8'hff)
                    found_end = 1'b1;
                else
                    num_patterns++;
            end
        end
        if (!found_end)
        begin
            error_count++;
            $display("Pattern file is missing or has no end marker line");
        end
        cycle_limit = (num_patterns + NUM_RANDOM + 3) * CYCLES_PER_TEST + 200;

        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;

        // Stored zeros with code zero still give zero
        check_result('0, "reset state");
        repeat (4) @(negedge clock);
        check_result('0, "idle after reset");

        for (i = 0; i < num_patterns; i++)
            run_test(pattern_mem[4*i], pattern_mem[4*i+1], pattern_mem[4*i+2][alu_pkg::OP_W-1:0],
                pattern_mem[4*i+3], $sformatf("pattern %0d", i));

        // Held button with the switches changing after the third edge
        run_test(8'h11, 8'h22, alu_pkg::OP_ADD, 8'h33, "held setup");
        sw = 16'h0040;
        button_a = 1'b1;
        repeat (3) @(negedge clock);
        sw = 16'h0099;                                 // Must not be stored
        repeat (7) @(negedge clock);
        button_a = 1'b0;
        repeat (8) @(negedge clock);
        check_result(expected_result(8'h40, 8'h22, alu_pkg::OP_ADD), "held capture");

        // Only B changes while the old A and code stay
        press_button(1, 16'h0005);
        repeat (6) @(negedge clock);
        check_result(expected_result(8'h40, 8'h05, alu_pkg::OP_ADD), "selective update");

        for (i = 0; i < NUM_RANDOM; i++)
        begin
            take_bits(alu_pkg::DATA_W, bits);
            a = bits[alu_pkg::DATA_W-1:0];
            take_bits(alu_pkg::DATA_W, bits);
            b = bits[alu_pkg::DATA_W-1:0];
            take_bits(3, bits);
            op = code_from_index(bits[2:0]);
            run_test(a, b, op, expected_result(a, b, op), $sformatf("random %0d op %h", i, op));
        end

        $display("Finished with %0d errors", error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* hw/alu_board_top.sv */
module alu_board_top (
    input  logic                     i_clock,
    input  logic                     i_rst,
    input  logic [alu_pkg::SW_W-1:0] i_sw,         // Slide switches
    input  logic                     i_button_a,   // Push buttons, raw
    input  logic                     i_button_b,
    input  logic                     i_button_op,
    output alu_pkg::operand_t        o_alu_result  // To the LEDs
);

    // Stored operands between control and ALU
    alu_pkg::operand_t alu_a;
    alu_pkg::operand_t alu_b;
    alu_pkg::opcode_t  alu_op;

    // Switch capture per button
    alu_input_ctrl u_input_ctrl (
        .i_clock     (i_clock),
        .i_rst       (i_rst),
        .i_sw        (i_sw),
        .i_button_a  (i_button_a),
        .i_button_b  (i_button_b),
        .i_button_op (i_button_op),
        .o_alu_a     (alu_a),
        .o_alu_b     (alu_b),
        .o_alu_op    (alu_op)
    );

    // Registered ALU, reads the stored values every cycle
    alu u_alu (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_alu_a      (alu_a),
        .i_alu_b      (alu_b),
        .i_alu_op     (alu_op),
        .o_alu_result (o_alu_result)
    );

endmodule

/* hw/alu.sv */
module alu (
    input  logic              i_clock,
    input  logic              i_rst,
    input  alu_pkg::operand_t i_alu_a,
    input  alu_pkg::operand_t i_alu_b,   // Also the shift amount
    input  alu_pkg::opcode_t  i_alu_op,
    output alu_pkg::operand_t o_alu_result
);

    alu_pkg::operand_t result_d;         // Combinational result
    alu_pkg::operand_t result_q;         // LED register
    alu_pkg::operand_t sra_res;
    alu_pkg::operand_t srl_res;

    // Shifts by B as unsigned amount
    // B of DATA_W or more leaves only fill bits
    assign srl_res = i_alu_a >> i_alu_b;
    assign sra_res = alu_pkg::operand_t'($signed(i_alu_a) >>> i_alu_b);

    // Operation select
    always_comb
    begin
        case (i_alu_op)
            alu_pkg::OP_ADD:
                result_d = i_alu_a + i_alu_b;       // Wraps at DATA_W
            alu_pkg::OP_SUB:
                result_d = i_alu_a - i_alu_b;       // Wraps below zero
            alu_pkg::OP_AND:
                result_d = i_alu_a & i_alu_b;
            alu_pkg::OP_OR:
                result_d = i_alu_a | i_alu_b;
            alu_pkg::OP_XOR:
                result_d = i_alu_a ^ i_alu_b;
            alu_pkg::OP_NOR:
                result_d = ~(i_alu_a | i_alu_b);
            alu_pkg::OP_SRL:
                result_d = srl_res;                 // Zero fill
            alu_pkg::OP_SRA:
                result_d = sra_res;                 // Sign fill from A
            default:
                result_d = '0;                      // Undefined code
        endcase
    end

    // Result loads every cycle, one cycle latency
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            result_q <= '0;
        end
        else
        begin
            result_q <= result_d;
        end
    end

    assign o_alu_result = result_q;

    // Stored operands and code come out of reset as zero,
    // so every cycle after reset must show a clean LED word
    a_result_known : assert property (
        @(posedge i_clock) disable iff (i_rst)
        !$isunknown(result_q)
    );

endmodule

/* hw/alu_input_ctrl.sv */
module alu_input_ctrl (
    input  logic                     i_clock,
    input  logic                     i_rst,
    input  logic [alu_pkg::SW_W-1:0] i_sw,        // Shared switch bank
    input  logic                     i_button_a,  // Store operand A
    input  logic                     i_button_b,  // Store operand B
    input  logic                     i_button_op, // Store operation code
    output alu_pkg::operand_t        o_alu_a,
    output alu_pkg::operand_t        o_alu_b,
    output alu_pkg::opcode_t         o_alu_op
);

    // Switch slices per payload
    // Operands use the low DATA_W switches
    logic [alu_pkg::DATA_W-1:0] sw_operand;
    // Code uses the low OP_W switches
    logic [alu_pkg::OP_W-1:0]   sw_opcode;

    assign sw_operand = i_sw[alu_pkg::DATA_W-1:0];
    assign sw_opcode  = i_sw[alu_pkg::OP_W-1:0];

    // Operand A register
    button_capture #(
        .payload_t (alu_pkg::operand_t)
    ) u_cap_a (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_button (i_button_a),
        .i_value  (sw_operand),
        .o_value  (o_alu_a)
    );

    // Operand B register, same slice as A
    button_capture #(
        .payload_t (alu_pkg::operand_t)
    ) u_cap_b (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_button (i_button_b),
        .i_value  (sw_operand),
        .o_value  (o_alu_b)
    );

    // Operation code register
    button_capture #(
        .payload_t (alu_pkg::opcode_t)
    ) u_cap_op (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_button (i_button_op),
        .i_value  (sw_opcode),
        .o_value  (o_alu_op)
    );

endmodule

/* hw/button_capture.sv */
module button_capture #(
    parameter type payload_t = logic   // Stored switch slice
) (
    input  logic     i_clock,
    input  logic     i_rst,
    input  logic     i_button,         // Raw board level, asynchronous
    input  payload_t i_value,          // Switch slice to store
    output payload_t o_value           // Held until next press
);

    // Synchronizer chain, index 0 sees the pad first
    logic [alu_pkg::SYNC_STAGES-1:0] sync_q;
    logic button_sync;                 // Last stage of the chain
    logic button_prev_q;               // One cycle older copy
    logic press;                       // Rising edge pulse
    payload_t value_q;

    assign button_sync = sync_q[alu_pkg::SYNC_STAGES-1];

    // Shift the raw level through the chain
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            sync_q <= '0;
        end
        else
        begin
            sync_q <= {sync_q[alu_pkg::SYNC_STAGES-2:0], i_button};
        end
    end

    // Delayed copy for edge detection
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            button_prev_q <= 1'b0;
        else
            button_prev_q <= button_sync;
    end

    // High only in the first cycle of a press
    assign press = button_sync & ~button_prev_q;

    // Load once per press; holding does nothing
    always_ff @(posedge i_clock)
    begin
        if (i_rst)
            value_q <= '0;            // Stored payload starts at zero
        else if (press)
            value_q <= i_value;        // Switches sampled here
    end

    assign o_value = value_q;

    // A press stores exactly once, however long the button is held
    a_press_single_cycle : assert property (
        @(posedge i_clock) disable iff (i_rst)
        press |=> !press
    );

endmodule

/* hw/alu_pkg.sv */
package alu_pkg;

    // Datapath sizes
    localparam int DATA_W = 8;       // Operand and result width
    localparam int OP_W = 6;         // Funct style operation code
    localparam int SW_W = 16;        // Slide switches on the board

    // Button synchronizer depth
    localparam int SYNC_STAGES = 2;

    // Arithmetic group
    localparam logic [OP_W-1:0] OP_ADD = 6'b100000;
    localparam logic [OP_W-1:0] OP_SUB = 6'b100010;

    // Bitwise logic group
    localparam logic [OP_W-1:0] OP_AND = 6'b100100;
    localparam logic [OP_W-1:0] OP_OR = 6'b100101;
    localparam logic [OP_W-1:0] OP_XOR = 6'b100110;
    localparam logic [OP_W-1:0] OP_NOR = 6'b100111;

    // Shifts, amount taken from operand B
    localparam logic [OP_W-1:0] OP_SRL = 6'b000010;  // Zero fill
    localparam logic [OP_W-1:0] OP_SRA = 6'b000011;  // Sign fill

    // Any code not listed above gives a zero result

    // Operand and result payload
    typedef logic [DATA_W-1:0] operand_t;

    // Operation code payload
    typedef logic [OP_W-1:0] opcode_t;

    // Low switches hold the operand value
    // Low six switches hold the code
    // Upper switches stay unused

    // Three buttons share the switches in time
    // Each press stores one payload

    // Widths checked against the switch bank
    // DATA_W and OP_W both fit inside SW_W

endpackage
